// File: design/cfg_regs.sv
`timescale 1ns/1ns

module cfg_regs
(
	input  logic                                clkcms,
	input  logic                                clr0,
	input  logic [dmb_reg_pkg::ADDR_W-1:0]      s_awaddr_i,
	input  logic                                s_awvalid_i,
	input  logic [dmb_reg_pkg::DATA_W-1:0]      s_wdata_i,
	input  logic                                s_wvalid_i,
	input  logic                                s_bready_i,
	input  logic [dmb_reg_pkg::ADDR_W-1:0]      s_araddr_i,
	input  logic                                s_arvalid_i,
	input  logic                                s_rready_i,
	input  logic                                ctrl_ready_i,
	input  logic [dmb_trig_pkg::TIMER_W-1:0]    timer_i,
	input  logic                                timer_done_i,
	output logic                                s_awready_o,
	output logic                                s_wready_o,
	output logic                                s_bvalid_o,
	output logic [1:0]                          s_bresp_o,
	output logic                                s_arready_o,
	output logic                                s_rvalid_o,
	output logic [dmb_reg_pkg::DATA_W-1:0]      s_rdata_o,
	output logic [1:0]                          s_rresp_o,
	output logic                                cable_dly_o,
	output logic                                snd_win_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   kill_mask_o,
	output logic                                timer_clr_o
);

	logic [dmb_reg_pkg::CTRL_W-1:0]   ctrl_q;
	logic                             wr_acc;
	logic                             rd_acc;
	logic                             wr_hit;
	logic                             rd_hit;
	logic [dmb_reg_pkg::DATA_W-1:0]   rd_mux;

	//////////////////////////////////////////////////////////////////////
	// Handshake and decode
	//////////////////////////////////////////////////////////////////////

	// No new request while a response of the same kind is held
	assign wr_acc = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
	assign rd_acc = s_arvalid_i && !s_rvalid_o;

	assign s_awready_o = wr_acc;
	assign s_wready_o  = wr_acc;
	assign s_arready_o = rd_acc;

	assign wr_hit = s_awaddr_i inside
		{dmb_reg_pkg::REG_CTRL, dmb_reg_pkg::REG_STATUS, dmb_reg_pkg::REG_TIMER};
	assign rd_hit = s_araddr_i inside
		{dmb_reg_pkg::REG_CTRL, dmb_reg_pkg::REG_STATUS, dmb_reg_pkg::REG_TIMER};

	// Any write to the timer register clears it
	assign timer_clr_o = wr_acc && (s_awaddr_i == dmb_reg_pkg::REG_TIMER);

	always_comb
	begin
		rd_mux = '0;
		case (s_araddr_i)
			dmb_reg_pkg::REG_CTRL:
				rd_mux[dmb_reg_pkg::CTRL_W-1:0] = ctrl_q;
			dmb_reg_pkg::REG_STATUS:
			begin
				rd_mux[dmb_reg_pkg::STAT_READY_BIT] = ctrl_ready_i;
				rd_mux[dmb_reg_pkg::STAT_DONE_BIT]  = timer_done_i;
			end
			dmb_reg_pkg::REG_TIMER:
				rd_mux[dmb_trig_pkg::TIMER_W-1:0] = timer_i;
			default:
				rd_mux = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Write channel and control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			ctrl_q     <= '0;
			s_bvalid_o <= 1'b0;
			s_bresp_o  <= dmb_reg_pkg::RESP_OKAY;
		end
		else if (wr_acc)
		begin
			s_bvalid_o <= 1'b1;
			s_bresp_o  <= wr_hit ? dmb_reg_pkg::RESP_OKAY : dmb_reg_pkg::RESP_SLVERR;
			if (s_awaddr_i == dmb_reg_pkg::REG_CTRL)
				ctrl_q <= s_wdata_i[dmb_reg_pkg::CTRL_W-1:0];
		end
		else if (s_bready_i)
			s_bvalid_o <= 1'b0;
	end

	assign cable_dly_o = ctrl_q[dmb_reg_pkg::CTRL_CDLY_BIT];
	assign snd_win_o   = ctrl_q[dmb_reg_pkg::CTRL_SWIN_BIT];
	assign kill_mask_o = ctrl_q[dmb_reg_pkg::CTRL_KILL_LSB +: dmb_trig_pkg::NUM_CFEB];

	//////////////////////////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			s_rvalid_o <= 1'b0;
			s_rresp_o  <= dmb_reg_pkg::RESP_OKAY;
		end
		else if (rd_acc)
		begin
			s_rvalid_o <= 1'b1;
			s_rresp_o  <= rd_hit ? dmb_reg_pkg::RESP_OKAY : dmb_reg_pkg::RESP_SLVERR;
		end
		else if (s_rready_i)
			s_rvalid_o <= 1'b0;
	end

	// Read data is captured with the request
	always_ff @(posedge clkcms)
	begin
		if (rd_acc)
			s_rdata_o <= rd_mux;
	end

	a_bvalid_hold: assert property (@(posedge clkcms) disable iff (clr0)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

	a_rvalid_hold: assert property (@(posedge clkcms) disable iff (clr0)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o)
			&& $stable(s_rresp_o));

endmodule

// File: design/dmb_ctrl_top.sv
`timescale 1ns/1ns

module dmb_ctrl_top
(
	input  logic                                clkcms,
	input  logic                                clr0,
	input  logic                                fpga_ready_i,
	input  logic [dmb_trig_pkg::NUM_CFEB:0]     lct_i,
	input  logic                                l1a_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   l1a_match_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   match_win0_i,
	input  logic [dmb_reg_pkg::ADDR_W-1:0]      s_awaddr_i,
	input  logic                                s_awvalid_i,
	input  logic [dmb_reg_pkg::DATA_W-1:0]      s_wdata_i,
	input  logic                                s_wvalid_i,
	input  logic                                s_bready_i,
	input  logic [dmb_reg_pkg::ADDR_W-1:0]      s_araddr_i,
	input  logic                                s_arvalid_i,
	input  logic                                s_rready_i,
	output logic                                ctrl_ready_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b0_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b1_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b2_o,
	output logic                                s_awready_o,
	output logic                                s_wready_o,
	output logic                                s_bvalid_o,
	output logic [1:0]                          s_bresp_o,
	output logic                                s_arready_o,
	output logic                                s_rvalid_o,
	output logic [dmb_reg_pkg::DATA_W-1:0]      s_rdata_o,
	output logic [1:0]                          s_rresp_o
);

	logic                                feb_rst;
	logic [dmb_trig_pkg::TIMER_W-1:0]    timer_val;
	logic                                timer_done;
	logic                                timer_clr;
	logic                                cable_dly;
	logic                                snd_win;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   kill_mask;

	//////////////////////////////////////////////////////////////////////
	// Startup and latency measurement
	//////////////////////////////////////////////////////////////////////

	startup_sequencer u_seq
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.fpga_ready_i (fpga_ready_i),
		.feb_rst_o    (feb_rst),
		.ctrl_ready_o (ctrl_ready_o)
	);

	// LCT on bit 0 starts the timer, L1A stops it
	lct_l1a_timer u_timer
	(
		.clkcms  (clkcms),
		.clr0    (clr0),
		.ready_i (ctrl_ready_o),
		.start_i (lct_i[0]),
		.stop_i  (l1a_i),
		.clr_i   (timer_clr),
		.time_o  (timer_val),
		.done_o  (timer_done)
	);

	//////////////////////////////////////////////////////////////////////
	// Trigger encoding and configuration
	//////////////////////////////////////////////////////////////////////

	trig_encoder u_enc
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.feb_rst_i    (feb_rst),
		.lct_i        (lct_i[dmb_trig_pkg::NUM_CFEB:1]),
		.l1a_i        (l1a_i),
		.l1a_match_i  (l1a_match_i),
		.match_win0_i (match_win0_i),
		.cable_dly_i  (cable_dly),
		.snd_win_i    (snd_win),
		.kill_mask_i  (kill_mask),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o)
	);

	cfg_regs u_regs
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.s_awaddr_i   (s_awaddr_i),
		.s_awvalid_i  (s_awvalid_i),
		.s_wdata_i    (s_wdata_i),
		.s_wvalid_i   (s_wvalid_i),
		.s_bready_i   (s_bready_i),
		.s_araddr_i   (s_araddr_i),
		.s_arvalid_i  (s_arvalid_i),
		.s_rready_i   (s_rready_i),
		.ctrl_ready_i (ctrl_ready_o),
		.timer_i      (timer_val),
		.timer_done_i (timer_done),
		.s_awready_o  (s_awready_o),
		.s_wready_o   (s_wready_o),
		.s_bvalid_o   (s_bvalid_o),
		.s_bresp_o    (s_bresp_o),
		.s_arready_o  (s_arready_o),
		.s_rvalid_o   (s_rvalid_o),
		.s_rdata_o    (s_rdata_o),
		.s_rresp_o    (s_rresp_o),
		.cable_dly_o  (cable_dly),
		.snd_win_o    (snd_win),
		.kill_mask_o  (kill_mask),
		.timer_clr_o  (timer_clr)
	);

endmodule

// File: design/dmb_reg_pkg.sv
package dmb_reg_pkg;

	// AXI4-Lite bus widths
	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	// Register map
	localparam logic [ADDR_W-1:0] REG_CTRL   = 'h0;
	localparam logic [ADDR_W-1:0] REG_STATUS = 'h4;
	localparam logic [ADDR_W-1:0] REG_TIMER  = 'h8;

	// REG_CTRL fields with one kill mask bit per CFEB
	localparam int CTRL_CDLY_BIT = 0;
	localparam int CTRL_SWIN_BIT = 1;
	localparam int CTRL_KILL_LSB = 2;
	localparam int CTRL_W        = CTRL_KILL_LSB + dmb_trig_pkg::NUM_CFEB;

	// REG_STATUS fields
	localparam int STAT_READY_BIT = 0;
	localparam int STAT_DONE_BIT  = 1;

	// Response codes on bresp and rresp
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_e;

endpackage

// File: design/dmb_trig_pkg.sv
package dmb_trig_pkg;

	// Front-end boards driven by the trigger encoder
	localparam int NUM_CFEB = 5;

	// LCT to L1A latency counter width
	localparam int TIMER_W = 10;

	// Startup periods in clkcms cycles
	localparam int FEBRST_CYCLES = 16;
	localparam int CRDY_CYCLES   = 16;

	// Shared down-counter sized for the longer of the two periods
	localparam int SEQ_CNT_W =
		$clog2((FEBRST_CYCLES > CRDY_CYCLES) ? FEBRST_CYCLES : CRDY_CYCLES);
	localparam logic [SEQ_CNT_W-1:0] FEBRST_LOAD = SEQ_CNT_W'(FEBRST_CYCLES - 1);
	localparam logic [SEQ_CNT_W-1:0] CRDY_LOAD   = SEQ_CNT_W'(CRDY_CYCLES - 1);

	// Per-CFEB trigger code on the three encoded lines
	typedef enum logic [2:0] {
		OP_IDLE      = 3'd0,
		OP_LCT       = 3'd1,
		OP_L1A       = 3'd2,
		OP_L1A_MATCH = 3'd3,
		OP_RESYNC    = 3'd7
	} trg_op_e;

	// Startup sequencer states
	typedef enum logic [1:0] {
		SEQ_WAIT,
		SEQ_FEBRST,
		SEQ_SETTLE,
		SEQ_READY
	} seq_state_e;

endpackage

// File: design/lct_l1a_timer.sv
`timescale 1ns/1ns

module lct_l1a_timer
(
	input  logic                               clkcms,
	input  logic                               clr0,
	input  logic                               ready_i,
	input  logic                               start_i,
	input  logic                               stop_i,
	input  logic                               clr_i,
	output logic [dmb_trig_pkg::TIMER_W-1:0]   time_o,
	output logic                               done_o
);

	logic counting;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			counting <= 1'b0;
			done_o   <= 1'b0;
			time_o   <= '0;
		end
		else if (clr_i)
		begin
			counting <= 1'b0;
			done_o   <= 1'b0;
			time_o   <= '0;
		end
		else if (counting)
		begin
			// L1A freezes the count
			if (stop_i)
			begin
				counting <= 1'b0;
				done_o   <= 1'b1;
			end
			else if (time_o != '1)
				time_o <= time_o + 1'b1;
		end
		// Start only from idle and only once the controller is ready
		else if (!done_o && ready_i && start_i)
		begin
			counting <= 1'b1;
			time_o   <= {{(dmb_trig_pkg::TIMER_W-1){1'b0}}, 1'b1};
		end
	end

	a_no_decrease: assert property (@(posedge clkcms) disable iff (clr0)
		!clr_i |=> time_o >= $past(time_o));

endmodule

// File: design/startup_sequencer.sv
`timescale 1ns/1ns

module startup_sequencer
(
	input  logic clkcms,
	input  logic clr0,
	input  logic fpga_ready_i,
	output logic feb_rst_o,
	output logic ctrl_ready_o
);

	dmb_trig_pkg::seq_state_e             state;
	logic                                 fpga_rdy_q;
	logic                                 rdy_rise;
	logic [dmb_trig_pkg::SEQ_CNT_W-1:0]   cnt;

	// Clock-ready rising edge
	assign rdy_rise = fpga_ready_i & ~fpga_rdy_q;

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			state      <= dmb_trig_pkg::SEQ_WAIT;
			fpga_rdy_q <= 1'b0;
			cnt        <= '0;
		end
		else
		begin
			fpga_rdy_q <= fpga_ready_i;
			// Losing the clock restarts the whole sequence
			if (!fpga_ready_i)
				state <= dmb_trig_pkg::SEQ_WAIT;
			else
			begin
				case (state)
					dmb_trig_pkg::SEQ_WAIT:
						if (rdy_rise)
						begin
							state <= dmb_trig_pkg::SEQ_FEBRST;
							cnt   <= dmb_trig_pkg::FEBRST_LOAD;
						end
					dmb_trig_pkg::SEQ_FEBRST:
						if (cnt == '0)
						begin
							state <= dmb_trig_pkg::SEQ_SETTLE;
							cnt   <= dmb_trig_pkg::CRDY_LOAD;
						end
						else
							cnt <= cnt - 1'b1;
					dmb_trig_pkg::SEQ_SETTLE:
						if (cnt == '0)
							state <= dmb_trig_pkg::SEQ_READY;
						else
							cnt <= cnt - 1'b1;
					default:
						state <= dmb_trig_pkg::SEQ_READY;
				endcase
			end
		end
	end

	assign feb_rst_o    = (state == dmb_trig_pkg::SEQ_FEBRST);
	assign ctrl_ready_o = (state == dmb_trig_pkg::SEQ_READY);

	a_rst_rdy_excl: assert property (@(posedge clkcms) disable iff (clr0)
		!(feb_rst_o && ctrl_ready_o));

	// Ready comes exactly one settling period after the end of resync
	a_rdy_after_rst: assert property (@(posedge clkcms) disable iff (clr0)
		$rose(ctrl_ready_o) |-> $past(feb_rst_o, dmb_trig_pkg::CRDY_CYCLES + 1));

endmodule

// File: design/trig_encoder.sv
`timescale 1ns/1ns

module trig_encoder
(
	input  logic                                clkcms,
	input  logic                                clr0,
	input  logic                                feb_rst_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   lct_i,
	input  logic                                l1a_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   l1a_match_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   match_win0_i,
	input  logic                                cable_dly_i,
	input  logic                                snd_win_i,
	input  logic [dmb_trig_pkg::NUM_CFEB-1:0]   kill_mask_i,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b0_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b1_o,
	output logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b2_o
);

	dmb_trig_pkg::trg_op_e                 op_c [dmb_trig_pkg::NUM_CFEB];
	logic [dmb_trig_pkg::NUM_CFEB-1:0]     match_c;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]     b0_c, b1_c, b2_c;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]     b0_q, b1_q, b2_q;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]     b0_qq, b1_qq, b2_qq;

	// Window mode shows match window position 0 in place of the L1A match
	assign match_c = snd_win_i ? match_win0_i : l1a_match_i;

	always_comb
	begin
		for (int i = 0; i < dmb_trig_pkg::NUM_CFEB; i++)
		begin
			if (feb_rst_i)
				op_c[i] = dmb_trig_pkg::OP_RESYNC;
			else if (kill_mask_i[i])
				op_c[i] = dmb_trig_pkg::OP_IDLE;
			else if (l1a_i && match_c[i])
				op_c[i] = dmb_trig_pkg::OP_L1A_MATCH;
			else if (l1a_i)
				op_c[i] = dmb_trig_pkg::OP_L1A;
			else if (lct_i[i])
				op_c[i] = dmb_trig_pkg::OP_LCT;
			else
				op_c[i] = dmb_trig_pkg::OP_IDLE;
			b0_c[i] = op_c[i][0];
			b1_c[i] = op_c[i][1];
			b2_c[i] = op_c[i][2];
		end
	end

	// Output stage plus the extra cable-delay stage
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			{b2_q, b1_q, b0_q}    <= '0;
			{b2_qq, b1_qq, b0_qq} <= '0;
		end
		else
		begin
			{b2_q, b1_q, b0_q}    <= {b2_c, b1_c, b0_c};
			{b2_qq, b1_qq, b0_qq} <= {b2_q, b1_q, b0_q};
		end
	end

	assign trg_enc_b0_o = cable_dly_i ? b0_qq : b0_q;
	assign trg_enc_b1_o = cable_dly_i ? b1_qq : b1_q;
	assign trg_enc_b2_o = cable_dly_i ? b2_qq : b2_q;

	for (genvar g = 0; g < dmb_trig_pkg::NUM_CFEB; g++)
	begin : g_op_chk
		a_op_legal: assert property (@(posedge clkcms) disable iff (clr0)
			{trg_enc_b2_o[g], trg_enc_b1_o[g], trg_enc_b0_o[g]} inside
			{dmb_trig_pkg::OP_IDLE, dmb_trig_pkg::OP_LCT, dmb_trig_pkg::OP_L1A,
			 dmb_trig_pkg::OP_L1A_MATCH, dmb_trig_pkg::OP_RESYNC});
	end

endmodule

// File: dmb_ctrl_top.f
+incdir+tb
design/dmb_trig_pkg.sv
design/dmb_reg_pkg.sv
design/startup_sequencer.sv
design/lct_l1a_timer.sv
design/trig_encoder.sv
design/cfg_regs.sv
design/dmb_ctrl_top.sv
tb/tb_dmb_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

TOP=tb_dmb_ctrl
BIN=sim_${TOP}

if ! verilator --binary --timing --assert -j 0 \
	--top-module "${TOP}" -f dmb_ctrl_top.f -o "${BIN}"; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$("./obj_dir/${BIN}")
sim_status=$?
echo "${sim_out}"

if [ ${sim_status} -ne 0 ]; then
	echo "Simulation exited with status ${sim_status}"
	exit 1
fi

if echo "${sim_out}" | grep -q "Test completed successfully"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation did not report a pass"
exit 1

// File: tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
	end
endtask

// Expected opcode by the priority rule below resync
function automatic logic [2:0] expected_op(input logic killed, input logic l1a,
	input logic match, input logic lct);
	if (killed)
		return dmb_trig_pkg::OP_IDLE;
	if (l1a)
		return match ? dmb_trig_pkg::OP_L1A_MATCH : dmb_trig_pkg::OP_L1A;
	return lct ? dmb_trig_pkg::OP_LCT : dmb_trig_pkg::OP_IDLE;
endfunction

function automatic logic [2:0] op_at(input int c);
	return {trg_enc_b2_o[c], trg_enc_b1_o[c], trg_enc_b0_o[c]};
endfunction

//////////////////////////////////////////////////////////////////////
// AXI4-Lite master
//////////////////////////////////////////////////////////////////////

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
	output logic [1:0] resp);
	int n;
	@(posedge clkcms);
	s_awaddr_i  <= addr;
	s_awvalid_i <= 1'b1;
	s_wdata_i   <= data;
	s_wvalid_i  <= 1'b1;
	n = 0;
	do
	begin
		@(negedge clkcms);
		n++;
	end
	while (!(s_awready_o && s_wready_o) && n < HS_LIMIT);
	if (!(s_awready_o && s_wready_o))
	begin
		$display("AXI write to 0x%0h was never accepted", addr);
		hs_errors++;
	end
	@(posedge clkcms);
	s_awvalid_i <= 1'b0;
	s_wvalid_i  <= 1'b0;
	@(negedge clkcms);
	check_eq(32'(s_bvalid_o), 32'd1, "bvalid one cycle after write accept");
	resp = s_bresp_o;
	// Response waits as long as bready stays low
	repeat (hold)
	begin
		@(negedge clkcms);
		check_eq(32'(s_bvalid_o), 32'd1, "bvalid held while bready is low");
	end
	@(posedge clkcms);
	s_bready_i <= 1'b1;
	@(posedge clkcms);
	s_bready_i <= 1'b0;
	@(negedge clkcms);
	check_eq(32'(s_bvalid_o), 32'd0, "bvalid cleared after bready");
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	int n;
	@(posedge clkcms);
	s_araddr_i  <= addr;
	s_arvalid_i <= 1'b1;
	n = 0;
	do
	begin
		@(negedge clkcms);
		n++;
	end
	while (!s_arready_o && n < HS_LIMIT);
	if (!s_arready_o)
	begin
		$display("AXI read from 0x%0h was never accepted", addr);
		hs_errors++;
	end
	@(posedge clkcms);
	s_arvalid_i <= 1'b0;
	@(negedge clkcms);
	check_eq(32'(s_rvalid_o), 32'd1, "rvalid one cycle after read accept");
	data = s_rdata_o;
	resp = s_rresp_o;
	@(posedge clkcms);
	s_rready_i <= 1'b1;
	@(posedge clkcms);
	s_rready_i <= 1'b0;
	@(negedge clkcms);
	check_eq(32'(s_rvalid_o), 32'd0, "rvalid cleared after rready");
endtask

task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
	logic [1:0] resp;
	axi_write(addr, data, 0, resp);
	check_eq(32'(resp), 32'(dmb_reg_pkg::RESP_OKAY), $sformatf("bresp at 0x%0h", addr));
endtask

task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp, input string msg);
	logic [31:0] data;
	logic [1:0]  resp;
	axi_read(addr, data, resp);
	check_eq(32'(resp), 32'(dmb_reg_pkg::RESP_OKAY), $sformatf("rresp at 0x%0h", addr));
	check_eq(data, exp, msg);
endtask

//////////////////////////////////////////////////////////////////////
// Trigger stimulus
//////////////////////////////////////////////////////////////////////

// One-cycle input pulse checked on the two following cycles
task automatic apply_trigger(input logic [4:0] lct, input logic l1a, input logic [4:0] match,
	input logic [4:0] win, input logic [4:0] kill, input logic swin, input int lat,
	input string tag);
	logic [2:0] exp_op [dmb_trig_pkg::NUM_CFEB];
	for (int i = 0; i < dmb_trig_pkg::NUM_CFEB; i++)
		exp_op[i] = expected_op(kill[i], l1a, swin ? win[i] : match[i], lct[i]);
	@(posedge clkcms);
	lct_i        <= {lct, 1'b0};
	l1a_i        <= l1a;
	l1a_match_i  <= match;
	match_win0_i <= win;
	@(posedge clkcms);
	lct_i        <= '0;
	l1a_i        <= 1'b0;
	l1a_match_i  <= '0;
	match_win0_i <= '0;
	for (int s = 1; s <= 2; s++)
	begin
		if (s == 2)
			@(posedge clkcms);
		@(negedge clkcms);
		for (int i = 0; i < dmb_trig_pkg::NUM_CFEB; i++)
			check_eq(32'(op_at(i)),
				(s == lat) ? 32'(exp_op[i]) : 32'(dmb_trig_pkg::OP_IDLE),
				$sformatf("%s, CFEB %0d, %0d cycles after input", tag, i + 1, s));
	end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_values();
	@(negedge clkcms);
	check_eq(32'(ctrl_ready_o), 32'd0, "ctrl_ready_o after reset");
	check_eq(32'({trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o}), 32'd0,
		"trigger outputs after reset");
	check_eq(32'({s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o}), 32'd0,
		"AXI ready and valid outputs after reset");
endtask

task automatic timer_holdoff();
	@(posedge clkcms);
	lct_i <= 6'b000001;
	@(posedge clkcms);
	lct_i <= '0;
	repeat (4) @(posedge clkcms);
	l1a_i <= 1'b1;
	@(posedge clkcms);
	l1a_i <= 1'b0;
	read_reg(dmb_reg_pkg::REG_TIMER, 32'd0, "timer after LCT before ready");
	read_reg(dmb_reg_pkg::REG_STATUS, 32'd0, "status before ready");
endtask

// Counts cycles from clock ready to ctrl_ready_o and the resync cycles on the way
task automatic wait_ready(output int n, output int resync_n);
	n        = 0;
	resync_n = 0;
	do
	begin
		@(posedge clkcms);
		n++;
		@(negedge clkcms);
		if (&{trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o})
			resync_n++;
	end
	while (!ctrl_ready_o && n < 40);
	if (!ctrl_ready_o)
	begin
		$display("ctrl_ready_o never rose after clock ready went high");
		hs_errors++;
	end
endtask

task automatic startup_sequence();
	int n;
	int resync_n;
	@(posedge clkcms);
	fpga_ready_i <= 1'b1;
	wait_ready(n, resync_n);
	check_eq(32'(n >= 32 && n <= 36), 32'd1,
		$sformatf("ctrl_ready_o rose %0d cycles after clock ready, allowed 32 to 36", n));
	check_eq(32'(resync_n), 32'(dmb_trig_pkg::FEBRST_CYCLES), "cycles of OP_RESYNC");
	check_eq(32'({trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o}), 32'd0, "idle after resync");
	// Losing clock ready drops the flag on the next edge
	@(posedge clkcms);
	fpga_ready_i <= 1'b0;
	@(posedge clkcms);
	@(negedge clkcms);
	check_eq(32'(ctrl_ready_o), 32'd0, "ctrl_ready_o after clock ready dropped");
	@(posedge clkcms);
	fpga_ready_i <= 1'b1;
	wait_ready(n, resync_n);
endtask

task automatic register_access();
	logic [31:0] v;
	logic [31:0] data;
	logic [1:0]  resp;
	v = $urandom;
	write_reg(dmb_reg_pkg::REG_CTRL, v);
	read_reg(dmb_reg_pkg::REG_CTRL, v & 32'h7f, "control register read back");
	read_reg(dmb_reg_pkg::REG_STATUS, 32'd1, "status with controller ready");
	axi_write(4'hc, $urandom, 0, resp);
	check_eq(32'(resp), 32'(dmb_reg_pkg::RESP_SLVERR), "bresp at unmapped address");
	axi_read(4'hc, data, resp);
	check_eq(32'(resp), 32'(dmb_reg_pkg::RESP_SLVERR), "rresp at unmapped address");
	read_reg(dmb_reg_pkg::REG_CTRL, v & 32'h7f, "control register after unmapped write");
	axi_write(dmb_reg_pkg::REG_CTRL, 32'd0, 5, resp);
	check_eq(32'(resp), 32'(dmb_reg_pkg::RESP_OKAY), "bresp after back-pressure");
endtask

task automatic encoding_latency();
	int         c;
	logic [4:0] oh;
	for (int d = 0; d < 2; d++)
	begin
		// Bit 0 adds the cable-delay stage
		write_reg(dmb_reg_pkg::REG_CTRL, 32'(d));
		for (int k = 0; k < 3; k++)
		begin
			c  = $urandom_range(dmb_trig_pkg::NUM_CFEB - 1, 0);
			oh = 5'b1 << c;
			apply_trigger(oh, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0, d + 1, "LCT only");
			apply_trigger(5'd0, 1'b1, 5'd0, 5'd0, 5'd0, 1'b0, d + 1, "L1A only");
			apply_trigger(5'd0, 1'b1, oh, 5'd0, 5'd0, 1'b0, d + 1, "L1A with match");
			apply_trigger(5'h1f, 1'b1, oh, 5'd0, 5'd0, 1'b0, d + 1, "LCT, L1A and match");
			apply_trigger(oh, 1'b0, oh, 5'd0, 5'd0, 1'b0, d + 1, "match without L1A");
		end
	end
endtask

task automatic kill_and_window();
	logic [4:0] kill;
	logic [4:0] win;
	kill = 5'($urandom_range(30, 1));
	write_reg(dmb_reg_pkg::REG_CTRL, {25'd0, kill, 2'b00});
	apply_trigger(5'h1f, 1'b1, 5'h1f, 5'd0, kill, 1'b0, 1, "kill mask, L1A with match");
	apply_trigger(5'd0, 1'b1, 5'd0, 5'd0, kill, 1'b0, 1, "kill mask, L1A only");
	// Window bits in place of the L1A match bits
	write_reg(dmb_reg_pkg::REG_CTRL, 32'h2);
	repeat (2)
	begin
		win = 5'($urandom);
		apply_trigger(5'd0, 1'b1, ~win, win, 5'd0, 1'b1, 1, "send window mode");
	end
	write_reg(dmb_reg_pkg::REG_CTRL, 32'd0);
endtask

task automatic latency_timer();
	int n;
	n = $urandom_range(200, 1);
	@(posedge clkcms);
	lct_i <= 6'b000001;
	@(posedge clkcms);
	lct_i <= '0;
	repeat (n - 1) @(posedge clkcms);
	l1a_i <= 1'b1;
	@(posedge clkcms);
	l1a_i <= 1'b0;
	read_reg(dmb_reg_pkg::REG_TIMER, 32'(n), $sformatf("timer for L1A %0d cycles after LCT", n));
	read_reg(dmb_reg_pkg::REG_STATUS, 32'd3, "status with timer done");
	write_reg(dmb_reg_pkg::REG_TIMER, $urandom);
	read_reg(dmb_reg_pkg::REG_TIMER, 32'd0, "timer after write");
	read_reg(dmb_reg_pkg::REG_STATUS, 32'd1, "status after timer write");
endtask

`endif

// File: tb/tb_dmb_ctrl.sv
`timescale 1ns/1ns

module tb_dmb_ctrl;

	// All tests together run for about 1000 cycles at most
	localparam int MAX_CYCLES = 3000;
	// Longest wait for one AXI handshake
	localparam int HS_LIMIT   = 16;

	logic                                clkcms;
	logic                                clr0;
	logic                                fpga_ready_i;
	logic [dmb_trig_pkg::NUM_CFEB:0]     lct_i;
	logic                                l1a_i;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   l1a_match_i;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   match_win0_i;
	logic [dmb_reg_pkg::ADDR_W-1:0]      s_awaddr_i;
	logic                                s_awvalid_i;
	logic [dmb_reg_pkg::DATA_W-1:0]      s_wdata_i;
	logic                                s_wvalid_i;
	logic                                s_bready_i;
	logic [dmb_reg_pkg::ADDR_W-1:0]      s_araddr_i;
	logic                                s_arvalid_i;
	logic                                s_rready_i;
	logic                                ctrl_ready_o;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b0_o;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b1_o;
	logic [dmb_trig_pkg::NUM_CFEB-1:0]   trg_enc_b2_o;
	logic                                s_awready_o;
	logic                                s_wready_o;
	logic                                s_bvalid_o;
	logic [1:0]                          s_bresp_o;
	logic                                s_arready_o;
	logic                                s_rvalid_o;
	logic [dmb_reg_pkg::DATA_W-1:0]      s_rdata_o;
	logic [1:0]                          s_rresp_o;

	int checks;
	int errors;
	int hs_errors;
	int cycles = 0;

	always #20 clkcms = ~clkcms;

	dmb_ctrl_top UUT
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.fpga_ready_i (fpga_ready_i),
		.lct_i        (lct_i),
		.l1a_i        (l1a_i),
		.l1a_match_i  (l1a_match_i),
		.match_win0_i (match_win0_i),
		.s_awaddr_i   (s_awaddr_i),
		.s_awvalid_i  (s_awvalid_i),
		.s_wdata_i    (s_wdata_i),
		.s_wvalid_i   (s_wvalid_i),
		.s_bready_i   (s_bready_i),
		.s_araddr_i   (s_araddr_i),
		.s_arvalid_i  (s_arvalid_i),
		.s_rready_i   (s_rready_i),
		.ctrl_ready_o (ctrl_ready_o),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o),
		.s_awready_o  (s_awready_o),
		.s_wready_o   (s_wready_o),
		.s_bvalid_o   (s_bvalid_o),
		.s_bresp_o    (s_bresp_o),
		.s_arready_o  (s_arready_o),
		.s_rvalid_o   (s_rvalid_o),
		.s_rdata_o    (s_rdata_o),
		.s_rresp_o    (s_rresp_o)
	);

	`include "tb_tasks.svh"

	// Watchdog on the whole run
	always @(posedge clkcms)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Run timed out after %0d clock cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clkcms       = 1'b0;
		clr0         = 1'b1;
		fpga_ready_i = 1'b0;
		lct_i        = '0;
		l1a_i        = 1'b0;
		l1a_match_i  = '0;
		match_win0_i = '0;
		s_awaddr_i   = '0;
		s_awvalid_i  = 1'b0;
		s_wdata_i    = '0;
		s_wvalid_i   = 1'b0;
		s_bready_i   = 1'b0;
		s_araddr_i   = '0;
		s_arvalid_i  = 1'b0;
		s_rready_i   = 1'b0;
		checks       = 0;
		errors       = 0;
		hs_errors    = 0;
		void'($urandom(32'h1314));

		repeat (3) @(posedge clkcms);
		clr0 <= 1'b0;

		reset_values();
		// Holdoff runs while the clock-ready input is still low
		timer_holdoff();
		startup_sequence();
		register_access();
		encoding_latency();
		kill_and_window();
		latency_timer();

		$display("Summary: %0d checks, %0d mismatches, %0d protocol or timing faults",
			checks, errors, hs_errors);
		if (errors == 0 && hs_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
